// ==== run.sh ====
#!/bin/sh
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert --top-module tb_hiddenLayer -f tb.f -o simHiddenLayer \
	&& ./obj_dir/simHiddenLayer > sim.log 2>&1 \
	|| { echo "Build or simulation run failed"; exit 1; }
cat sim.log
grep -q "SOME TESTS FAILED" sim.log && { echo "Simulation reported failures"; exit 1; }
grep -q "ALL TESTS PASSED" sim.log || { echo "Simulation ended without a verdict"; exit 1; }
exit 0

// ==== tb.f ====
+incdir+verification
verilog/neuralPkg.sv
verilog/floatMultiply.sv
verilog/floatAdd.sv
verilog/neuronNode.sv
verilog/hiddenLayer.sv
verification/tb_hiddenLayer.sv

// ==== verification/tbFloatModel.svh ====
`ifndef TB_FLOAT_MODEL_SVH
`define TB_FLOAT_MODEL_SVH

logic [31:0] randomState = 32'd3636;

// 32-bit xorshift, shifts 13, 17, 5
function automatic logic [31:0] nextRandom();
	randomState = randomState ^ (randomState << 13);
	randomState = randomState ^ (randomState >> 17);
	randomState = randomState ^ (randomState << 5);
	return randomState;
endfunction

function automatic real pow2(input int exponent);
	real result;
	result = 1.0;
	for (int i = 0; i < exponent; i++)
		result = result * 2.0;
	for (int i = 0; i > exponent; i--)
		result = result / 2.0;
	return result;
endfunction

function automatic real bitsToReal(input neuralPkg::floatWord bits);
	real magnitude;
	if (bits[30:23] == 8'd0)
		return 0.0; // Denormals read as zero
	magnitude = (1.0 + real'(bits[22:0]) / pow2(23))
		* pow2(int'(bits[30:23]) - neuralPkg::ExponentBias);
	return bits[31] ? -magnitude : magnitude;
endfunction

// Rounds a real to single precision, nearest even, flush-to-zero, saturating
function automatic real roundToSingle(input real value);
	real magnitude;
	real scaled;
	real remainder;
	int exponent;
	if (value == 0.0)
		return 0.0;
	magnitude = (value < 0.0) ? -value : value;
	exponent = 0;
	while (magnitude >= 2.0)
	begin
		magnitude = magnitude / 2.0;
		exponent++;
	end
	while (magnitude < 1.0)
	begin
		magnitude = magnitude * 2.0;
		exponent--;
	end
	scaled = magnitude * pow2(23);
	remainder = scaled - $floor(scaled);
	scaled = $floor(scaled);
	if (remainder > 0.5 || (remainder == 0.5 && $floor(scaled / 2.0) * 2.0 != scaled))
		scaled = scaled + 1.0;
	if (scaled >= pow2(24))
	begin
		scaled = scaled / 2.0;
		exponent++;
	end
	if (exponent < 1 - neuralPkg::ExponentBias)
		return 0.0;
	if (exponent > neuralPkg::ExponentBias)
		magnitude = bitsToReal({1'b0, neuralPkg::FloatMaxFinite});
	else
		magnitude = scaled * pow2(exponent - 23);
	return (value < 0.0) ? -magnitude : magnitude;
endfunction

function automatic real nodeModel(input int node, input activationSet values);
	real terms [neuralPkg::InputCount + 1];
	int width;
	for (int i = 0; i < neuralPkg::InputCount; i++)
		terms[i] = roundToSingle(bitsToReal(values[i])
			* bitsToReal(neuralPkg::NodeWeights[node][i]));
	terms[neuralPkg::InputCount] = bitsToReal(neuralPkg::NodeBiases[node]);
	width = neuralPkg::InputCount + 1;
	while (width > 1)
	begin
		for (int i = 0; i < width / 2; i++)
			terms[i] = roundToSingle(terms[2 * i] + terms[2 * i + 1]); // Neighbours in order
		width = width / 2;
	end
	return (terms[0] > 0.0) ? terms[0] : 0.0; // ReLU
endfunction

function automatic bit withinTolerance(input real expected, input real actual);
	real difference;
	real scale;
	difference = (expected > actual) ? expected - actual : actual - expected;
	scale = (expected < 0.0) ? -expected : expected;
	return (difference <= pow2(-120)) || (difference <= pow2(-20) * scale);
endfunction

`endif

// ==== verification/tb_hiddenLayer.sv ====
`timescale 1ns/1ps

module tb_hiddenLayer;

	typedef neuralPkg::floatWord [neuralPkg::InputCount-1:0] activationSet;

	localparam int ClockPeriod = 20;
	localparam int ResetCycles = 5;
	localparam int DriveDelay = 2;
	localparam int IdleCycles = 6;
	localparam int RandomSets = 50;
	localparam int BackToBackSets = 8;
	localparam int ExtremeSets = 4;
	localparam int TestCount = 6;
	localparam int DrainLimit = 8;
	localparam int TotalStrobes = 1 + neuralPkg::InputCount + RandomSets + BackToBackSets
		+ ExtremeSets;
	localparam int WatchdogCycles = ResetCycles + IdleCycles + 2 * TotalStrobes
		+ TestCount * (DrainLimit + 2) + 10;

	logic clk;
	logic reset;
	logic activationStrobe;
	activationSet activations;
	neuralPkg::floatWord [neuralPkg::NodeCount-1:0] nodeOutputs;
	logic outputStrobe;

	real expectedQueue[$]; // One entry per node for each set
	int testQueue[$];
	string testNames [1:TestCount];
	int testFailures [1:TestCount];
	int currentTest;
	int strobeCount;
	int checkTest;
	bit checkDue;
	bit strobeUnexpected;
	bit [neuralPkg::NodeCount-1:0] valueMatch;
	real expectedValue [neuralPkg::NodeCount];
	real actualValue [neuralPkg::NodeCount];

	`include "tbFloatModel.svh"

	hiddenLayer u_hiddenLayer (
		.clk(clk),
		.reset(reset),
		.activationStrobe(activationStrobe),
		.activations(activations),
		.nodeOutputs(nodeOutputs),
		.outputStrobe(outputStrobe)
	);

	initial
	begin
		clk = 1'b0;
		forever #(ClockPeriod / 2) clk = ~clk;
	end

	// Outputs are settled at the falling edge
	always @(negedge clk)
	begin
		checkDue = outputStrobe && !reset;
		strobeUnexpected = 1'b0;
		valueMatch = '1;
		if (checkDue && testQueue.size() == 0)
			strobeUnexpected = 1'b1;
		else if (checkDue)
		begin
			checkTest = testQueue.pop_front();
			for (int n = 0; n < neuralPkg::NodeCount; n++)
			begin
				expectedValue[n] = expectedQueue.pop_front();
				actualValue[n] = bitsToReal(nodeOutputs[n]);
				valueMatch[n] = withinTolerance(expectedValue[n], actualValue[n]);
			end
		end
	end

	task automatic reportMismatch(input int node);
		$display("Fail %s: node %0d expected %g actual %g", testNames[checkTest], node,
			expectedValue[node], actualValue[node]);
		testFailures[checkTest]++;
	endtask

	outputArrival: assert property (@(posedge clk) checkDue |-> !strobeUnexpected)
		else
		begin
			$display("Output strobe arrived with no result set outstanding");
			testFailures[currentTest]++;
		end

	firstNodeValue: assert property (@(posedge clk) checkDue |-> valueMatch[0])
		else reportMismatch(0);

	secondNodeValue: assert property (@(posedge clk) checkDue |-> valueMatch[1])
		else reportMismatch(1);

	idleAfterReset: assert property (@(negedge clk) disable iff (reset)
		strobeCount == 0 |-> !outputStrobe && nodeOutputs == '0)
		else
		begin
			$display("Outputs moved before any strobe was applied");
			testFailures[currentTest]++;
		end

	strobeLatency: assert property (@(negedge clk) disable iff (reset)
		!$past(reset, 1) && !$past(reset, 2) |-> outputStrobe == $past(activationStrobe, 2))
		else
		begin
			$display("Output strobe did not follow the activation strobe by two cycles");
			testFailures[currentTest]++;
		end

	exclusiveSign: assert property (@(negedge clk) disable iff (reset)
		outputStrobe |-> (nodeOutputs[0] == '0 || nodeOutputs[1] == '0))
		else
		begin
			$display("Both nodes gave a positive output for the same set");
			testFailures[currentTest]++;
		end

	function automatic activationSet oneHotSet(input int position);
		activationSet values;
		values = '0;
		values[position] = 32'h3F80_0000; // 1.0
		return values;
	endfunction

	function automatic activationSet randomSet();
		activationSet values;
		logic [31:0] signAndExponent;
		logic [31:0] fraction;
		logic [7:0] exponent;
		for (int i = 0; i < neuralPkg::InputCount; i++)
		begin
			signAndExponent = nextRandom();
			fraction = nextRandom();
			exponent = 8'(32'd117 + (signAndExponent % 32'd21)); // Unbiased -10 to +10
			values[i] = {signAndExponent[31], exponent, fraction[22:0]};
		end
		return values;
	endfunction

	function automatic activationSet denormalSet();
		activationSet values;
		logic [31:0] draw;
		for (int i = 0; i < neuralPkg::InputCount; i++)
		begin
			draw = nextRandom();
			values[i] = {draw[31], 8'h00, draw[22:0] | 23'h1};
		end
		return values;
	endfunction

	// Same sign as the node 0 weight when matchSigns is set, else positive
	function automatic activationSet scaledSet(input logic [7:0] exponent, input bit matchSigns);
		activationSet values;
		logic signBit;
		for (int i = 0; i < neuralPkg::InputCount; i++)
		begin
			signBit = matchSigns ? neuralPkg::NodeWeights[0][i][31] : 1'b0;
			values[i] = {signBit, exponent, 23'h7F_FFFF};
		end
		return values;
	endfunction

	task automatic applySet(input activationSet values);
		@(posedge clk);
		#DriveDelay;
		activations = values;
		activationStrobe = 1'b1;
		strobeCount++;
		for (int n = 0; n < neuralPkg::NodeCount; n++)
			expectedQueue.push_back(nodeModel(n, values));
		testQueue.push_back(currentTest);
	endtask

	task automatic releaseStrobe();
		@(posedge clk);
		#DriveDelay;
		activationStrobe = 1'b0;
	endtask

	task automatic finishTest();
		int waited;
		waited = 0;
		while (testQueue.size() != 0 && waited < DrainLimit)
		begin
			@(posedge clk);
			waited++;
		end
		if (testQueue.size() != 0)
		begin
			$display("Test %0d: %0d result sets never arrived", currentTest, testQueue.size());
			testFailures[currentTest]++;
			testQueue.delete();
			expectedQueue.delete();
		end
		repeat (2) @(posedge clk); // Last value check fires here
		$display("Test %0d %s: %s", currentTest, testNames[currentTest],
			(testFailures[currentTest] == 0) ? "passed" : "failed");
	endtask

	initial
	begin
		#(WatchdogCycles * ClockPeriod);
		$display("Watchdog expired after %0d cycles", WatchdogCycles);
		$display("SOME TESTS FAILED");
		$finish;
	end

	initial
	begin
		int passCount;
		int failCount;
		activationStrobe = 1'b0;
		activations = '0;
		reset = 1'b1;
		strobeCount = 0;
		currentTest = 1;
		testNames[1] = "reset idle";
		testNames[2] = "zero activations";
		testNames[3] = "one hot";
		testNames[4] = "random sets";
		testNames[5] = "back to back";
		testNames[6] = "denormal and huge";
		for (int t = 1; t <= TestCount; t++)
			testFailures[t] = 0;
		repeat (ResetCycles) @(posedge clk);
		#DriveDelay;
		reset = 1'b0;

		repeat (IdleCycles) @(posedge clk);
		finishTest();

		currentTest = 2;
		applySet('0);
		releaseStrobe();
		finishTest();

		currentTest = 3;
		for (int p = 0; p < neuralPkg::InputCount; p++)
		begin
			applySet(oneHotSet(p));
			releaseStrobe();
		end
		finishTest();

		currentTest = 4;
		for (int s = 0; s < RandomSets; s++)
		begin
			applySet(randomSet());
			releaseStrobe();
		end
		finishTest();

		currentTest = 5;
		for (int s = 0; s < BackToBackSets; s++)
			applySet(randomSet()); // Strobe stays high across sets
		releaseStrobe();
		finishTest();

		currentTest = 6;
		applySet(denormalSet());
		releaseStrobe();
		applySet(scaledSet(8'd250, 1'b0));
		releaseStrobe();
		applySet(scaledSet(8'd250, 1'b1));
		releaseStrobe();
		applySet(scaledSet(8'd254, 1'b1)); // Node 0 sum overflows
		releaseStrobe();
		finishTest();

		passCount = 0;
		failCount = 0;
		for (int t = 1; t <= TestCount; t++)
		begin
			if (testFailures[t] == 0)
				passCount++;
			else
				failCount++;
		end
		$display("Tests passed: %0d, failed: %0d", passCount, failCount);
		if (failCount == 0)
			$display("ALL TESTS PASSED");
		else
			$display("SOME TESTS FAILED");
		$finish;
	end

endmodule

// ==== verilog/floatAdd.sv ====
`timescale 1ns/1ps

module floatAdd (
	input neuralPkg::floatWord augend,
	input neuralPkg::floatWord addend,
	output neuralPkg::floatWord sum
);

	logic [30:0] magnitudeA;
	logic [30:0] magnitudeB;
	logic [30:0] bigMagnitude;
	logic [30:0] smallMagnitude;
	logic swapOperands;
	logic bigSign;
	logic effectiveSubtract;
	neuralPkg::exponentField bigExponent;
	neuralPkg::exponentField smallExponent;
	neuralPkg::exponentField exponentDifference;
	logic [23:0] bigSignificand;
	logic [23:0] smallSignificand;
	logic [4:0] shiftAmount;
	logic [53:0] alignWindow;
	logic [26:0] alignedSmall;
	logic [27:0] rawSum;
	logic [4:0] leadingZeros;
	logic [27:0] normalizedSum;
	neuralPkg::mantissaField truncatedMantissa;
	neuralPkg::mantissaField mantissaOut;
	logic guardBit;
	logic stickyBit;
	logic roundUp;
	logic [24:0] roundedSignificand;
	logic signed [10:0] sumExponent;
	logic signed [10:0] finalExponent;

	// Denormal operands are treated as zero
	assign magnitudeA = (augend[30:23] == '0) ? '0 : augend[30:0];
	assign magnitudeB = (addend[30:23] == '0) ? '0 : addend[30:0];

	assign swapOperands = magnitudeB > magnitudeA;
	assign bigMagnitude = swapOperands ? magnitudeB : magnitudeA;
	assign smallMagnitude = swapOperands ? magnitudeA : magnitudeB;
	assign bigSign = swapOperands ? addend[31] : augend[31];
	assign effectiveSubtract = augend[31] ^ addend[31];

	assign bigExponent = bigMagnitude[30:23];
	assign smallExponent = smallMagnitude[30:23];
	assign bigSignificand = {|bigExponent, bigMagnitude[22:0]};
	assign smallSignificand = {|smallExponent, smallMagnitude[22:0]};

	assign exponentDifference = bigExponent - smallExponent;
	assign shiftAmount = (exponentDifference > 8'd27) ? 5'd27 : exponentDifference[4:0];

	// Upper 27 bits hold significand with GRS, lower 27 catch what shifts out
	assign alignWindow = {smallSignificand, 30'b0} >> shiftAmount;
	assign alignedSmall = {alignWindow[53:28], alignWindow[27] | (|alignWindow[26:0])};

	assign rawSum = effectiveSubtract ? {1'b0, bigSignificand, 3'b000} - {1'b0, alignedSmall}
		: {1'b0, bigSignificand, 3'b000} + {1'b0, alignedSmall};

	always_comb
	begin
		leadingZeros = 5'd28;
		for (int i = 0; i < 28; i++)
		begin
			if (rawSum[i])
				leadingZeros = 5'(27 - i); // Highest set bit wins
		end
	end

	assign normalizedSum = rawSum << leadingZeros;
	assign sumExponent = {3'b000, bigExponent} + 11'sd1 - {6'b0, leadingZeros};

	assign truncatedMantissa = normalizedSum[26:4];
	assign guardBit = normalizedSum[3];
	assign stickyBit = |normalizedSum[2:0];
	assign roundUp = guardBit & (stickyBit | truncatedMantissa[0]);

	assign roundedSignificand = {2'b01, truncatedMantissa} + {24'b0, roundUp};
	assign mantissaOut = roundedSignificand[24] ? roundedSignificand[23:1]
		: roundedSignificand[22:0];
	assign finalExponent = sumExponent + {10'b0, roundedSignificand[24]};

	always_comb
	begin
		if (rawSum == '0)
			sum = '0; // Exact cancellation is positive zero
		else if (finalExponent >= 255)
			sum = {bigSign, neuralPkg::FloatMaxFinite};
		else if (finalExponent <= 0)
			sum = {bigSign, 31'b0};
		else
			sum = {bigSign, finalExponent[7:0], mantissaOut};
	end

endmodule

// ==== verilog/floatMultiply.sv ====
`timescale 1ns/1ps

module floatMultiply (
	input neuralPkg::floatWord multiplicand,
	input neuralPkg::floatWord multiplier,
	output neuralPkg::floatWord product
);

	neuralPkg::exponentField exponentA;
	neuralPkg::exponentField exponentB;
	neuralPkg::mantissaField mantissaA;
	neuralPkg::mantissaField mantissaB;
	neuralPkg::mantissaField truncatedMantissa;
	neuralPkg::mantissaField mantissaOut;
	logic productSign;
	logic operandZero;
	logic [47:0] significandProduct;
	logic guardBit;
	logic stickyBit;
	logic roundUp;
	logic [24:0] roundedSignificand;
	logic signed [10:0] productExponent;
	logic signed [10:0] finalExponent;

	assign exponentA = multiplicand[30:23];
	assign exponentB = multiplier[30:23];
	assign mantissaA = multiplicand[22:0];
	assign mantissaB = multiplier[22:0];
	assign productSign = multiplicand[31] ^ multiplier[31];
	assign operandZero = (exponentA == '0) || (exponentB == '0); // Denormals count as zero

	assign significandProduct = {24'b0, 1'b1, mantissaA}
		* {24'b0, 1'b1, mantissaB}; // Lies in [2^46, 2^48)

	always_comb
	begin
		if (significandProduct[47])
		begin
			truncatedMantissa = significandProduct[46:24];
			guardBit = significandProduct[23];
			stickyBit = |significandProduct[22:0];
		end
		else
		begin
			truncatedMantissa = significandProduct[45:23];
			guardBit = significandProduct[22];
			stickyBit = |significandProduct[21:0];
		end
	end

	assign productExponent = {3'b000, exponentA} + {3'b000, exponentB}
		- 11'(neuralPkg::ExponentBias) + {10'b0, significandProduct[47]};

	// Round to nearest, ties to even
	assign roundUp = guardBit & (stickyBit | truncatedMantissa[0]);
	assign roundedSignificand = {2'b01, truncatedMantissa} + {24'b0, roundUp};
	assign mantissaOut = roundedSignificand[24] ? roundedSignificand[23:1]
		: roundedSignificand[22:0];
	assign finalExponent = productExponent + {10'b0, roundedSignificand[24]};

	always_comb
	begin
		if (operandZero || finalExponent <= 0)
			product = {productSign, 31'b0}; // Flush to signed zero
		else if (finalExponent >= 255)
			product = {productSign, neuralPkg::FloatMaxFinite};
		else
			product = {productSign, finalExponent[7:0], mantissaOut};
	end

endmodule

// ==== verilog/hiddenLayer.sv ====
`timescale 1ns/1ps

module hiddenLayer (
	input logic clk,
	input logic reset,
	input logic activationStrobe,
	input neuralPkg::floatWord [neuralPkg::InputCount-1:0] activations,
	output neuralPkg::floatWord [neuralPkg::NodeCount-1:0] nodeOutputs,
	output logic outputStrobe
);

	genvar nodeNumber;

	// Nodes run in lockstep, so node 0 alone reports the strobe
	generate
		for (nodeNumber = 0; nodeNumber < neuralPkg::NodeCount; nodeNumber++)
		begin : nodes
			if (nodeNumber == 0)
			begin : leadNode
				neuronNode #(
					.NodeIndex(nodeNumber)
				) u_node (
					.clk(clk),
					.reset(reset),
					.activationStrobe(activationStrobe),
					.activations(activations),
					.nodeOutput(nodeOutputs[nodeNumber]),
					.outputStrobe(outputStrobe)
				);
			end
			else
			begin : followerNode
				neuronNode #(
					.NodeIndex(nodeNumber)
				) u_node (
					.clk(clk),
					.reset(reset),
					.activationStrobe(activationStrobe),
					.activations(activations),
					.nodeOutput(nodeOutputs[nodeNumber]),
					.outputStrobe()
				);
			end
		end
	endgenerate

endmodule

// ==== verilog/neuralPkg.sv ====
package neuralPkg;

	typedef logic [31:0] floatWord; // IEEE single precision
	typedef logic [7:0] exponentField;
	typedef logic [22:0] mantissaField;

	localparam int ExponentBias = 127;
	localparam logic [30:0] FloatMaxFinite = 31'h7F7F_FFFF; // Exponent 254 with all-ones fraction

	localparam int InputCount = 15;
	localparam int NodeCount = 2;

	// Row 1 mirrors row 0 with every sign flipped
	localparam floatWord NodeWeights [NodeCount][InputCount] = '{
		'{
			32'hBEC4_A2AD,
			32'h3E89_1267,
			32'hBF1E_828F,
			32'h3D9A_35BF,
			32'h3E8E_8E8C,
			32'h3EBD_D06F,
			32'h3E0C_24BB,
			32'h3DE8_7987,
			32'hBD2A_B37E,
			32'hBF0C_922B,
			32'h3E96_04A9,
			32'hBEAD_786D,
			32'hBD33_59FD,
			32'hBE83_63F2,
			32'h3EFD_F12B
		},
		'{
			32'h3EC4_A2AD,
			32'hBE89_1267,
			32'h3F1E_828F,
			32'hBD9A_35BF,
			32'hBE8E_8E8C,
			32'hBEBD_D06F,
			32'hBE0C_24BB,
			32'hBDE8_7987,
			32'h3D2A_B37E,
			32'h3F0C_922B,
			32'hBE96_04A9,
			32'h3EAD_786D,
			32'h3D33_59FD,
			32'h3E83_63F2,
			32'hBEFD_F12B
		}
	};

	localparam floatWord NodeBiases [NodeCount] = '{
		32'h3CA3_21C5, // Positive reference bias
		32'hBCA3_21C5
	};

endpackage

// ==== verilog/neuronNode.sv ====
`timescale 1ns/1ps

module neuronNode #(
	parameter int NodeIndex = 0
) (
	input logic clk,
	input logic reset,
	input logic activationStrobe,
	input neuralPkg::floatWord [neuralPkg::InputCount-1:0] activations,
	output neuralPkg::floatWord nodeOutput,
	output logic outputStrobe
);

	localparam int LeafCount = neuralPkg::InputCount + 1; // Products plus bias
	localparam int TreeSize = 2 * LeafCount - 1;

	neuralPkg::floatWord products [neuralPkg::InputCount];
	neuralPkg::floatWord productReg [neuralPkg::InputCount];
	neuralPkg::floatWord treeTerms [TreeSize];
	neuralPkg::floatWord treeSum;
	neuralPkg::floatWord reluSum;
	logic productStrobe;

	genvar term;
	genvar adder;

	generate
		for (term = 0; term < neuralPkg::InputCount; term++)
		begin : multiplyStage
			floatMultiply u_multiply (
				.multiplicand(activations[term]),
				.multiplier(neuralPkg::NodeWeights[NodeIndex][term]),
				.product(products[term])
			);

			assign treeTerms[term] = productReg[term];
		end
	endgenerate

	assign treeTerms[neuralPkg::InputCount] = neuralPkg::NodeBiases[NodeIndex];

	always_ff @(posedge clk)
	begin
		if (activationStrobe)
			productReg <= products;
	end

	always_ff @(posedge clk)
	begin
		if (reset)
			productStrobe <= 1'b0;
		else
			productStrobe <= activationStrobe;
	end

	// Adder k sums terms 2k and 2k+1 into slot LeafCount+k, so levels follow in order
	generate
		for (adder = 0; adder < LeafCount - 1; adder++)
		begin : addTree
			floatAdd u_add (
				.augend(treeTerms[2 * adder]),
				.addend(treeTerms[2 * adder + 1]),
				.sum(treeTerms[LeafCount + adder])
			);
		end
	endgenerate

	assign treeSum = treeTerms[TreeSize - 1];
	assign reluSum = treeSum[31] ? '0 : treeSum; // ReLU

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			nodeOutput <= '0;
			outputStrobe <= 1'b0;
		end
		else
		begin
			outputStrobe <= productStrobe;
			if (productStrobe)
				nodeOutput <= reluSum;
		end
	end

	strobeLatency: assert property (@(posedge clk) disable iff (reset)
		!$past(reset, 1) && !$past(reset, 2) |-> outputStrobe == $past(activationStrobe, 2));

	nonNegativeOutput: assert property (@(posedge clk) disable iff (reset)
		!nodeOutput[31]);

endmodule
